// ==== list.f ====
+incdir+include
src/fetch_pkg.sv
src/pc_gen.sv
src/redirect_hold.sv
src/ibus_request.sv
src/fetch_predecode.sv
src/fetch_frontend.sv
dv/ibus_model.sv
dv/tb_fetch_frontend.sv

// ==== dv/tb_fetch_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch_frontend;

    logic                     clk;
    logic                     reset;
    fetch_pkg::redirect_req_t backend_redirect;
    fetch_pkg::ibus_req_t     ireq;
    fetch_pkg::ibus_resp_t    iresp;
    fetch_pkg::fetch_pkt_t    fetch_pkt;
    logic                     credit_return = 1'b0;

    // reference state
    logic [`WORD_W-1:0] exp_pc;
    logic               halted;
    logic               withhold;
    int                 delivered;
    int                 issued;
    int                 in_flight;
    int                 jumps_seen;
    int                 branches_seen;
    int                 exc_seen;

    fetch_frontend fetch_frontend_i (
        .clk,
        .reset,
        .backend_redirect,
        .ireq,
        .iresp,
        .fetch_pkt,
        .credit_return
    );

    ibus_model ibus_model_i (
        .clk,
        .reset,
        .ireq,
        .iresp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic value_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // slot against the content rule and the predecode target rules
    task automatic check_slot(input fetch_pkg::fetch_slot_t s, input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] nxt;
        w = ibus_model_i.word_at(a);
        nxt = a + 4;
        assert (s.valid && s.pc == a) else value_error("slot pc off the reference stream");
        assert (s.instr == w) else value_error("instruction differs from content rule");
        case (w[31:26])
            `OP_J, `OP_JAL: begin
                assert (s.ctl == fetch_pkg::CTL_JUMP && s.target == {nxt[31:28], w[25:0], 2'b00})
                    else value_error("jump target wrong");
                jumps_seen++;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                assert (s.ctl == fetch_pkg::CTL_BRANCH &&
                        s.target == nxt + {{14{w[15]}}, w[15:0], 2'b00})
                    else value_error("branch target wrong");
                branches_seen++;
            end
            default: begin
                assert (s.ctl == fetch_pkg::CTL_NONE) else value_error("plain word tagged");
            end
        endcase
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        logic [31:0] pair;
        logic [31:0] w0;
        logic [31:0] nxt;
        if (!reset) begin
            assert (delivered - issued <= `FETCH_CREDITS) else value_error("credit bound exceeded");
            // bus requests accepted and not yet answered
            if (ireq.valid && iresp.addr_ok) begin
                in_flight++;
            end
            if (iresp.data_ok) begin
                in_flight--;
            end
            assert (in_flight <= `IBUS_MAX_OUTSTANDING)
                else value_error("too many bus requests outstanding");
            if (fetch_pkt.valid) begin
                assert (!halted) else value_error("packet after misaligned halt");
                delivered++;
                if (fetch_pkt.exc_misaligned) begin
                    assert (fetch_pkt.slot[0].pc == exp_pc) else value_error("bad pc not reported");
                    halted = 1'b1;
                    exc_seen++;
                end else begin
                    pair = {exp_pc[31:3], 3'b000};
                    w0 = ibus_model_i.word_at(pair);
                    assert (fetch_pkt.slot[0].valid == !exp_pc[2]) else value_error("slot 0 valid wrong");
                    if (!exp_pc[2]) begin
                        check_slot(fetch_pkt.slot[0], pair);
                    end
                    check_slot(fetch_pkt.slot[1], pair + 4);
                    // jump in slot 0 steers after its delay slot
                    if (!exp_pc[2] && (w0[31:26] == `OP_J || w0[31:26] == `OP_JAL)) begin
                        nxt = pair + 32'd4;
                        exp_pc = {nxt[31:28], w0[25:0], 2'b00};
                    end else begin
                        exp_pc = pair + 8;
                    end
                end
            end
            // back end wins over anything predecode did this cycle
            if (backend_redirect.valid) begin
                if (backend_redirect.kind == fetch_pkg::REDIR_EXC) begin
                    exp_pc = `EXC_ENTRY;
                end else begin
                    exp_pc = backend_redirect.target;
                end
                halted = 1'b0;
            end
        end
    end

    // decode side returns one credit per packet
    always @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else if (!withhold && delivered > issued) begin
            credit_return <= 1'b1;
            issued++;
        end else begin
            credit_return <= 1'b0;
        end
    end

    task automatic wait_packets(input int n);
        int target;
        int t;
        target = delivered + n;
        for (t = 0; t < 2000 && delivered < target; t++) begin
            @(posedge clk);
        end
        if (delivered < target) begin
            plain_error("timed out waiting for fetch packets");
        end
    endtask

    task automatic send_redirect(input fetch_pkg::redirect_kind_t k, input logic [31:0] t);
        @(posedge clk);
        backend_redirect <= '{valid: 1'b1, kind: k, target: t};
        @(posedge clk);
        backend_redirect <= '0;
    endtask

    initial begin
        int t;
        backend_redirect = '0;
        reset = 1'b1;
        withhold = 1'b0;
        halted = 1'b0;
        exp_pc = `RESET_PC;
        delivered = 0;
        issued = 0;
        in_flight = 0;
        jumps_seen = 0;
        branches_seen = 0;
        exc_seen = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // sequential pairs through the jump loop
        wait_packets(12);
        assert (ibus_model_i.first_addr == `RESET_PC) else value_error("first request not reset pc");

        // no credits back, fetch must stall at the limit
        withhold <= 1'b1;
        repeat (40) @(posedge clk);
        assert (delivered - issued == `FETCH_CREDITS) else value_error("fetch did not use all credits");
        withhold <= 1'b0;
        wait_packets(8);

        // back-end redirects, upper-word entry first
        send_redirect(fetch_pkg::REDIR_BRANCH, 32'hbfc0_0204);
        wait_packets(4);
        send_redirect(fetch_pkg::REDIR_EXC, 32'h0);
        wait_packets(4);
        send_redirect(fetch_pkg::REDIR_ERET, 32'hbfc0_0040);
        wait_packets(6);

        // misaligned target, one exception packet then silence
        send_redirect(fetch_pkg::REDIR_BRANCH, 32'hbfc0_0202);
        for (t = 0; t < 500 && exc_seen == 0; t++) begin
            @(posedge clk);
        end
        if (exc_seen == 0) begin
            plain_error("timed out waiting for the misaligned exception packet");
        end
        repeat (30) @(posedge clk);
        send_redirect(fetch_pkg::REDIR_BRANCH, `RESET_PC);
        wait_packets(20);

        assert (jumps_seen > 0 && branches_seen > 0) else value_error("control words never fetched");
        assert (exc_seen == 1) else value_error("exception packet count wrong");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ibus_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module ibus_model (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::ibus_req_t  ireq,
    output fetch_pkg::ibus_resp_t iresp
);

    integer             seed = 61618;
    int                 cyc;
    int                 accepted;
    logic [`WORD_W-1:0] first_addr;

    // accepted addresses and the cycle each may return
    logic [`WORD_W-1:0] addr_q [$];
    int                 due_q [$];

    // ADDI r1 with the low address bits
    // except a few jumps and one branch forming a loop
    function automatic logic [`WORD_W-1:0] word_at(input logic [`WORD_W-1:0] a);
        case (a)
            32'hbfc0_0010: word_at = {`OP_J, 26'h3f0_0041};
            32'hbfc0_011c: word_at = {`OP_J, 26'h3f0_0000};
            32'hbfc0_0130: word_at = {`OP_J, 26'h3f0_0000};
            32'hbfc0_0108: word_at = {`OP_BEQ, 5'd0, 5'd0, 16'h0010};
            default:       word_at = {6'd8, 5'd0, 5'd1, a[15:0]};
        endcase
    endfunction

    initial begin
        iresp = '0;
        accepted = 0;
        first_addr = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            addr_q.delete();
            due_q.delete();
            cyc = 0;
            iresp <= '0;
        end else begin
            cyc++;
            if (ireq.valid && iresp.addr_ok) begin
                addr_q.push_back(ireq.addr);
                // 1 to 4 cycles after acceptance
                due_q.push_back(cyc + ($random(seed) & 3));
                accepted++;
                if (accepted == 1) begin
                    first_addr = ireq.addr;
                end
            end
            // accept about three cycles in four
            iresp.addr_ok <= ($random(seed) & 3) != 0;
            if (addr_q.size() > 0 && due_q[0] <= cyc) begin
                iresp.data_ok <= 1'b1;
                iresp.data    <= {word_at(addr_q[0] + 4), word_at(addr_q[0])};
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                iresp.data_ok <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_frontend (
    input  logic                    clk,
    input  logic                    reset,
    input  fetch_pkg::redirect_req_t backend_redirect,
    output fetch_pkg::ibus_req_t    ireq,
    input  fetch_pkg::ibus_resp_t   iresp,
    output fetch_pkg::fetch_pkt_t   fetch_pkt,
    input  logic                    credit_return
);

    // pc side
    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] pair_addr;
    logic               req_allowed;
    logic               load_redirect;
    logic               halt;

    // bus side
    logic               req_accepted;
    logic               req_waiting;
    logic               resp_keep;
    logic [`WORD_W-1:0] resp_pc;

    fetch_pkg::redirect_req_t pending;
    fetch_pkg::redirect_req_t jump_redirect;

    pc_gen pc_gen_i (
        .clk,
        .reset,
        .pending,
        .req_accepted,
        .req_waiting,
        .halt,
        .pc,
        .pair_addr,
        .req_allowed,
        .load_redirect
    );

    redirect_hold redirect_hold_i (
        .clk,
        .reset,
        .backend_redirect,
        .jump_redirect,
        .load_redirect,
        .pending
    );

    // a pending redirect marks everything in flight as wrong path
    ibus_request ibus_request_i (
        .clk,
        .reset,
        .pc,
        .pair_addr,
        .req_allowed,
        .redirect_seen (pending.valid),
        .ireq,
        .iresp,
        .credit_return,
        .req_accepted,
        .req_waiting,
        .resp_keep,
        .resp_pc
    );

    fetch_predecode fetch_predecode_i (
        .clk,
        .reset,
        .resp_keep,
        .resp_data     (iresp.data),
        .resp_pc,
        .pc_misaligned (pc[1:0] != 2'b00),
        .fetch_pkt,
        .jump_redirect,
        .halt
    );

endmodule

`default_nettype wire

// ==== src/fetch_predecode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_predecode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     resp_keep,
    input  logic [`PAIR_W-1:0]       resp_data,
    input  logic [`WORD_W-1:0]       resp_pc,
    input  logic                     pc_misaligned,
    output fetch_pkg::fetch_pkt_t    fetch_pkt,
    output fetch_pkg::redirect_req_t jump_redirect,
    output logic                     halt
);

    localparam logic [`WORD_W-1:0] WORD_STEP = 4;

    fetch_pkg::fetch_pkt_t pkt_next;
    logic [`WORD_W-1:0]    pair_pc;
    logic                  halt_q;

    // tag one slot with its control kind and target
    function automatic fetch_pkg::fetch_slot_t decode_slot(
        input logic [`WORD_W-1:0]   spc,
        input fetch_pkg::instr_word_t w,
        input logic                 v
    );
        fetch_pkg::fetch_slot_t s;
        logic [`WORD_W-1:0]     pc_p4;
        pc_p4    = spc + WORD_STEP;
        s.valid  = v;
        s.pc     = spc;
        s.instr  = w;
        s.ctl    = fetch_pkg::CTL_NONE;
        s.target = '0;
        case (w.i_form.opcode)
            `OP_J, `OP_JAL: begin
                // region of the delay slot, index in words
                s.ctl    = fetch_pkg::CTL_JUMP;
                s.target = {pc_p4[`WORD_W-1 -: 4], w.j_form.index, 2'b00};
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                // offset from the delay slot
                s.ctl    = fetch_pkg::CTL_BRANCH;
                s.target = pc_p4 + {{(`WORD_W - 18){w.i_form.imm[15]}},
                                    w.i_form.imm, 2'b00};
            end
            default: begin
                s.ctl = fetch_pkg::CTL_NONE;
            end
        endcase
        return s;
    endfunction

    assign pair_pc = {resp_pc[`WORD_W-1:3], 3'b000};

    always_comb begin
        pkt_next.valid          = 1'b1;
        pkt_next.exc_misaligned = pc_misaligned;
        // low word is the lower address
        // slot 0 dropped when the pc entered at the upper word
        pkt_next.slot[0] = decode_slot(pair_pc, resp_data[`WORD_W-1:0], !resp_pc[2]);
        pkt_next.slot[1] = decode_slot(pair_pc + WORD_STEP,
                                       resp_data[`PAIR_W-1:`WORD_W], 1'b1);
        if (pc_misaligned) begin
            // bad pc reported in slot 0, nothing to execute
            pkt_next.slot[0]       = '0;
            pkt_next.slot[0].pc    = resp_pc;
            pkt_next.slot[1]       = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pkt.valid <= 1'b0;
        end else if (resp_keep) begin
            fetch_pkt <= pkt_next;
        end else begin
            fetch_pkt.valid <= 1'b0;
        end
    end

    // jump in slot 0, its delay slot already sits in slot 1
    always_comb begin
        jump_redirect.valid  = fetch_pkt.valid && !fetch_pkt.exc_misaligned &&
                               fetch_pkt.slot[0].valid &&
                               fetch_pkt.slot[0].ctl == fetch_pkg::CTL_JUMP;
        jump_redirect.kind   = fetch_pkg::REDIR_BRANCH;
        jump_redirect.target = fetch_pkt.slot[0].target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (resp_keep && pc_misaligned) begin
            halt_q <= 1'b1;
        end else if (!pc_misaligned) begin
            halt_q <= 1'b0;
        end
    end

    // drops as soon as a redirect moves the pc off the bad address
    assign halt = halt_q && pc_misaligned;

endmodule

`default_nettype wire

// ==== src/ibus_request.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module ibus_request (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`WORD_W-1:0]    pc,
    input  logic [`WORD_W-1:0]    pair_addr,
    input  logic                  req_allowed,
    input  logic                  redirect_seen,
    output fetch_pkg::ibus_req_t  ireq,
    input  fetch_pkg::ibus_resp_t iresp,
    input  logic                  credit_return,
    output logic                  req_accepted,
    output logic                  req_waiting,
    output logic                  resp_keep,
    output logic [`WORD_W-1:0]    resp_pc
);

    localparam int MAX_OUT = `IBUS_MAX_OUTSTANDING;
    localparam int OUT_W   = $clog2(MAX_OUT + 1);
    localparam int CRED_W  = $clog2(`FETCH_CREDITS + 1);
    localparam int PTR_W   = $clog2(MAX_OUT);

    logic [OUT_W-1:0]  out_cnt;
    logic [OUT_W-1:0]  out_next;
    logic [OUT_W-1:0]  disc_cnt;
    logic [CRED_W-1:0] credits;
    logic              hold_req;
    logic              can_issue;
    logic              data_ok;
    logic              discard_now;
    logic              exc_grant;
    logic              exc_sent;

    // pc of each accepted request, oldest at rd_ptr
    logic [`WORD_W-1:0] pc_q [MAX_OUT];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;

    assign data_ok = iresp.data_ok;

    // a stalled request keeps valid up until addr_ok
    assign can_issue = req_allowed && (credits != '0) && (out_cnt < OUT_W'(MAX_OUT));
    assign ireq.valid = hold_req || can_issue;
    assign ireq.addr  = pair_addr;

    assign req_accepted = ireq.valid && iresp.addr_ok;
    assign req_waiting  = ireq.valid && !iresp.addr_ok;

    // wrong path, either marked earlier or in flight right now
    assign discard_now = data_ok && ((disc_cnt != '0) || redirect_seen);

    // misaligned pc gets one slot toward decode, no bus traffic
    // bus must be drained so it stays behind older packets
    assign exc_grant = (pc[1:0] != 2'b00) && !exc_sent && !redirect_seen &&
                       (out_cnt == '0) && (credits != '0);

    assign resp_keep = (data_ok && !discard_now) || exc_grant;
    assign resp_pc   = exc_grant ? pc : pc_q[rd_ptr];

    assign out_next = out_cnt + OUT_W'(req_accepted) - OUT_W'(data_ok);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt  <= '0;
            disc_cnt <= '0;
            credits  <= CRED_W'(`FETCH_CREDITS);
            hold_req <= 1'b0;
            exc_sent <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            out_cnt  <= out_next;
            hold_req <= req_waiting;
            // redirect: whatever is still out after this edge is stale
            if (redirect_seen) begin
                disc_cnt <= out_next;
            end else if (data_ok && disc_cnt != '0) begin
                disc_cnt <= disc_cnt - 1'b1;
            end
            // spend on accept or exception slot, refund on return or drop
            credits <= credits + CRED_W'(credit_return) + CRED_W'(discard_now)
                     - CRED_W'(req_accepted) - CRED_W'(exc_grant);
            if (redirect_seen) begin
                exc_sent <= 1'b0;
            end else if (exc_grant) begin
                exc_sent <= 1'b1;
            end
            if (req_accepted) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (data_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // pc queue payload
    always_ff @(posedge clk) begin
        if (req_accepted) begin
            pc_q[wr_ptr] <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/redirect_hold.sv ====
`timescale 1ns/1ns
`default_nettype none

module redirect_hold (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::redirect_req_t backend_redirect,
    input  fetch_pkg::redirect_req_t jump_redirect,
    input  logic                     load_redirect,
    output fetch_pkg::redirect_req_t pending
);

    fetch_pkg::redirect_req_t held;
    fetch_pkg::redirect_req_t incoming;
    logic                     take_incoming;

    // back end resolves older instructions, so it beats predecode
    assign incoming = backend_redirect.valid ? backend_redirect : jump_redirect;

    // exc over eret over branch
    // equal kind, the newer one wins
    assign take_incoming = incoming.valid &&
                           (!held.valid || incoming.kind >= held.kind);

    // visible in the same cycle it arrives
    assign pending = take_incoming ? incoming : held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held.valid <= 1'b0;
        end else if (load_redirect) begin
            // pc takes it on this edge
            held.valid <= 1'b0;
        end else begin
            held <= pending;
        end
    end

endmodule

`default_nettype wire

// ==== src/pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module pc_gen (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::redirect_req_t pending,
    input  logic                     req_accepted,
    input  logic                     req_waiting,
    input  logic                     halt,
    output logic [`WORD_W-1:0]       pc,
    output logic [`WORD_W-1:0]       pair_addr,
    output logic                     req_allowed,
    output logic                     load_redirect
);

    // distance between two fetch pairs
    localparam logic [`WORD_W-1:0] PAIR_STEP = 8;

    logic [`WORD_W-1:0] pc_next;
    logic               pc_misaligned;

    assign pc_misaligned = pc[1:0] != 2'b00;

    // pair base, bit 2 dropped
    assign pair_addr = {pc[`WORD_W-1:3], 3'b000};

    // a waiting request pins the address, so redirect waits too
    assign load_redirect = pending.valid && !req_waiting;

    // no new request while a redirect is about to replace the pc
    assign req_allowed = !halt && !pc_misaligned && !pending.valid;

    always_comb begin
        pc_next = pc;
        if (load_redirect) begin
            if (pending.kind == fetch_pkg::REDIR_EXC) begin
                pc_next = `EXC_ENTRY;
            end else begin
                // eret and branch both carry their target
                pc_next = pending.target;
            end
        end else if (req_accepted) begin
            pc_next = pair_addr + PAIR_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // one instruction word, read as immediate form or jump form
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_form;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } j_form;
    } instr_word_t;

    // encoding order is the priority order, exc highest
    typedef enum logic [1:0] {
        REDIR_BRANCH = 2'd0,
        REDIR_ERET   = 2'd1,
        REDIR_EXC    = 2'd2
    } redirect_kind_t;

    // target unused for REDIR_EXC
    typedef struct packed {
        logic                valid;
        redirect_kind_t      kind;
        logic [`WORD_W-1:0]  target;
    } redirect_req_t;

    typedef struct packed {
        logic               valid;
        logic [`WORD_W-1:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic               addr_ok;
        logic               data_ok;
        logic [`PAIR_W-1:0] data;
    } ibus_resp_t;

    typedef enum logic [1:0] {
        CTL_NONE   = 2'd0,
        CTL_BRANCH = 2'd1,
        CTL_JUMP   = 2'd2
    } ctl_kind_t;

    typedef struct packed {
        logic               valid;
        logic [`WORD_W-1:0] pc;
        instr_word_t        instr;
        ctl_kind_t          ctl;
        logic [`WORD_W-1:0] target;
    } fetch_slot_t;

    // slot[0] is the lower address of the pair
    typedef struct packed {
        logic             valid;
        logic             exc_misaligned;
        fetch_slot_t [1:0] slot;
    } fetch_pkt_t;

endpackage

`default_nettype wire

// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first pair fetched after reset
`define RESET_PC 32'hbfc0_0000

// general exception vector, boot space
`define EXC_ENTRY 32'hbfc0_0380

// instruction and address width
`define WORD_W 32

// one response carries two words
`define PAIR_W 64

// packets decode can hold at reset
`define FETCH_CREDITS 4

// accepted requests still waiting for data
`define IBUS_MAX_OUTSTANDING 2

// jump opcodes, j_form
`define OP_J   6'd2
`define OP_JAL 6'd3

// conditional branch opcodes, i_form
`define OP_BEQ  6'd4
`define OP_BNE  6'd5
`define OP_BLEZ 6'd6
`define OP_BGTZ 6'd7

`endif
